// File: all.f
+incdir+dv
verilog/corePkg.sv
verilog/busArbiter.sv
verilog/fetchStage.sv
verilog/instrDecoder.sv
verilog/decodeStage.sv
verilog/executeStage.sv
verilog/memoryStage.sv
verilog/regFile.sv
verilog/rvCore.sv
dv/coreTb.sv

// File: run.sh
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module coreTb -f all.f -o coreSim \
    > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/coreSim > sim.log 2>&1
grep -q "STATUS: FAIL" sim.log && { echo "simulation failed, see sim.log"; exit 1; }
grep -q "STATUS: PASS" sim.log || { echo "simulation ended without passing"; exit 1; }
echo "simulation passed"

// File: dv/isaModel.svh
localparam int    numInstr = 60;
localparam word_t dataBase = 32'h400;

typedef enum int {
    opAdd, opSub, opAnd, opOr, opXor, opSlt, opAddi, opAndi, opOri, opXori, opLui,
    opLw, opSw, opBeq, opBne, opJal
} modelOp_t;

modelOp_t opOf [numInstr];
regIdx_t  rdOf [numInstr];
regIdx_t  rs1Of [numInstr];
regIdx_t  rs2Of [numInstr];
word_t    immOf [numInstr];
word_t    mem [512];          // Program from address 0 and data region at dataBase
word_t    dataImage [16];     // Data region as the model sees it
word_t    expPc [$];
regIdx_t  expDst [$];
word_t    expData [$];
word_t    storeAddr [$];
word_t    storeData [$];

function automatic word_t fillWord(word_t addr);
    return (addr * 32'h9e37_79b9) ^ {addr[15:0], addr[31:16]};
endfunction

function automatic word_t encode(modelOp_t op, regIdx_t rd, regIdx_t rs1, regIdx_t rs2,
                                 word_t imm);
    logic [2:0] f3;
    case (op)
        opAnd, opAndi:      f3 = 3'b111;
        opOr, opOri:        f3 = 3'b110;
        opXor, opXori:      f3 = 3'b100;
        opSlt, opLw, opSw:  f3 = 3'b010;
        opBne:              f3 = 3'b001;
        default:            f3 = 3'b000;
    endcase
    case (op)
        opAdd, opAnd, opOr, opXor, opSlt: return {7'h00, rs2, rs1, f3, rd, 7'b0110011};
        opSub:                            return {7'h20, rs2, rs1, f3, rd, 7'b0110011};
        opAddi, opAndi, opOri, opXori:    return {imm[11:0], rs1, f3, rd, 7'b0010011};
        opLui:                            return {imm[31:12], rd, 7'b0110111};
        opLw:                             return {imm[11:0], rs1, f3, rd, 7'b0000011};
        opSw: return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
        opBeq, opBne: return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
        default:      return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endcase
endfunction

task automatic fillMemory();
    for (int a = 0; a < 512; a++)
        mem[a] = fillWord(word_t'(a) << 2);
    for (int k = 0; k < 16; k++)
        dataImage[k] = mem[(dataBase >> 2) + k];
endtask

task automatic buildProgram();
    int    pick;
    int    target;
    word_t rnd;
    for (int i = 0; i < numInstr; i++) begin
        pick     = $urandom % 16;
        rnd      = $urandom;
        target   = i + 2 + $urandom % 3;
        rdOf[i]  = regIdx_t'(1 + $urandom % 7);
        rs1Of[i] = regIdx_t'(1 + $urandom % 7);
        rs2Of[i] = regIdx_t'(1 + $urandom % 7);
        immOf[i] = {{20{rnd[11]}}, rnd[11:0]};
        if (target > numInstr - 1)
            target = numInstr - 1;
        if (i < 7) begin    // Every register gets a value before it is read
            opOf[i]  = opAddi;
            rdOf[i]  = regIdx_t'(i + 1);
            rs1Of[i] = '0;
        end else if (i == numInstr - 1) begin    // Halt
            opOf[i]  = opJal;
            rdOf[i]  = '0;
            immOf[i] = '0;
        end else if (pick <= 10) begin
            opOf[i] = modelOp_t'(pick);
            if (opOf[i] == opLui)
                immOf[i] = {rnd[31:12], 12'b0};
        end else if (pick <= 13) begin    // Word access based on x0
            opOf[i]  = (pick == 13) ? opSw : opLw;
            rs1Of[i] = '0;
            immOf[i] = dataBase + (word_t'(rnd[31:28]) << 2);
        end else begin
            opOf[i] = (pick == 15) ? opJal : (rnd[31] ? opBne : opBeq);
            if (rnd[30])
                rs2Of[i] = rs1Of[i];    // Equal operands so that more branches are taken
            immOf[i] = word_t'((target - i) * 4);
        end
        mem[i] = encode(opOf[i], rdOf[i], rs1Of[i], rs2Of[i], immOf[i]);
    end
endtask

task automatic runModel();
    word_t xr [32];
    word_t a, b, res;
    logic  writes;
    int    i, next;
    xr = '{default: '0};
    i  = 0;
    while (i < numInstr) begin
        a      = xr[rs1Of[i]];
        b      = xr[rs2Of[i]];
        res    = '0;
        writes = 1'b1;
        next   = i + 1;
        case (opOf[i])
            opAdd:  res = a + b;
            opSub:  res = a - b;
            opAnd:  res = a & b;
            opOr:   res = a | b;
            opXor:  res = a ^ b;
            opSlt:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            opAddi: res = a + immOf[i];
            opAndi: res = a & immOf[i];
            opOri:  res = a | immOf[i];
            opXori: res = a ^ immOf[i];
            opLui:  res = immOf[i];
            opLw:   res = dataImage[immOf[i][5:2]];
            opSw: begin
                writes = 1'b0;
                dataImage[immOf[i][5:2]] = b;
                storeAddr.push_back(immOf[i]);
                storeData.push_back(b);
            end
            opBeq, opBne: begin
                writes = 1'b0;
                if ((a == b) == (opOf[i] == opBeq))
                    next = i + int'(immOf[i] >> 2);
            end
            default: begin    // JAL links pc plus 4
                res  = word_t'(i * 4 + 4);
                next = i + int'(immOf[i] >> 2);
            end
        endcase
        expPc.push_back(word_t'(i * 4));
        expDst.push_back(writes ? rdOf[i] : '0);
        expData.push_back(res);
        if (writes && rdOf[i] != '0)
            xr[rdOf[i]] = res;
        i = (i == numInstr - 1) ? numInstr : next;
    end
endtask

// File: dv/coreTb.sv
`timescale 1ns/1ns

module coreTb;
    import corePkg::*;

    `include "isaModel.svh"

    localparam int cycleLimit = numInstr * 2 * 5 + 200;

    logic    clk, reset, pready;
    logic    psel, penable, pwrite, retireValid;
    word_t   prdata, paddr, pwdata, retirePc, retireData;
    regIdx_t retireDst;
    logic    nextReady, busy, busStarted;
    word_t   nextData;
    int      waitsLeft, retireCount, storeCount, cycleCount;

    rvCore #(.resetPc(32'h0)) dut_i (
        .clk, .reset, .prdata, .pready, .paddr, .psel, .penable, .pwrite, .pwdata,
        .retireValid, .retirePc, .retireDst, .retireData
    );

    always #5 clk = ~clk;

    task automatic stopWithFail(string why);
        $display("%s", why);
        $display("STATUS: FAIL");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic checkWord(string name, word_t expected, word_t actual);
        if (actual !== expected)
            stopWithFail($sformatf("Mismatch %s: expected %h, actual %h", name, expected, actual));
    endtask

    task automatic checkReg(string name, regIdx_t expected, regIdx_t actual);
        if (actual !== expected)
            stopWithFail($sformatf("Mismatch %s: expected x%0d, actual x%0d", name, expected,
                                   actual));
    endtask

    task automatic finishRun();
        if (storeCount != storeAddr.size()) begin
            stopWithFail($sformatf("Only %0d of %0d stores reached the bus before halt",
                                   storeCount, storeAddr.size()));
        end else begin
            $display("STATUS: PASS");
            $finish;
        end
    endtask

    task automatic checkStore();
        if (storeCount >= storeAddr.size())
            stopWithFail("APB write seen after all stores of the program were done");
        checkWord($sformatf("store %0d address", storeCount), storeAddr[storeCount], paddr);
        checkWord($sformatf("store %0d data", storeCount), storeData[storeCount], pwdata);
        mem[paddr[10:2]] = pwdata;
        storeCount++;
    endtask

    // APB slave, sampled on the falling edge, outputs applied on the next rising edge
    task automatic serveBus();
        if (penable && !busy)
            stopWithFail("penable went high without a setup cycle");
        if (psel && !penable && busy)
            stopWithFail("new setup cycle before the last transfer completed");
        if (!psel && busy)
            stopWithFail("psel dropped in the middle of a transfer");
        if (psel && !penable) begin
            busStarted = 1'b1;
            busy       = 1'b1;
            waitsLeft  = $urandom % 4;
            nextReady  = waitsLeft == 0;
            nextData   = mem[paddr[10:2]];
        end else if (psel && penable) begin
            if (pready) begin    // Completes on the coming edge
                if (pwrite)
                    checkStore();
                busy      = 1'b0;
                nextReady = 1'b0;
            end else begin
                waitsLeft--;
                nextReady = waitsLeft == 0;
            end
        end
    endtask

    task automatic checkRetire();
        if (retireValid) begin
            if (retireCount >= expPc.size())
                stopWithFail("More instructions retired than the model executed");
            checkWord($sformatf("retire %0d pc", retireCount), expPc[retireCount], retirePc);
            checkReg($sformatf("retire %0d dst", retireCount), expDst[retireCount], retireDst);
            if (expDst[retireCount] != '0)
                checkWord($sformatf("retire %0d data", retireCount), expData[retireCount],
                          retireData);
            retireCount++;
            if (retireCount == expPc.size())
                finishRun();
        end
    endtask

    initial begin
        clk         = 1'b0;
        reset       = 1'b1;
        pready      = 1'b0;
        prdata      = '0;
        nextReady   = 1'b0;
        nextData    = '0;
        busy        = 1'b0;
        busStarted  = 1'b0;
        waitsLeft   = 0;
        retireCount = 0;
        storeCount  = 0;
        cycleCount  = 0;
        void'($urandom(32'h2e24_47ca));
        fillMemory();
        buildProgram();
        runModel();
        repeat (3) @(posedge clk);
        reset <= 1'b0;
    end

    always @(posedge clk) begin
        pready <= nextReady;
        prdata <= nextData;
        if (!reset) begin
            cycleCount++;
            if (cycleCount >= cycleLimit)
                stopWithFail($sformatf("Timeout, halt did not retire within %0d cycles",
                                       cycleLimit));
        end
    end

    always @(negedge clk) begin
        if (reset) begin
            if (psel !== 1'b0 || penable !== 1'b0 || retireValid !== 1'b0)
                stopWithFail("Bus or retire port active during reset");
        end else begin
            if (!busStarted && (penable !== 1'b0 || retireValid !== 1'b0))
                stopWithFail("penable or retireValid high before the first bus transfer");
            serveBus();
            checkRetire();
        end
    end

endmodule

// File: verilog/rvCore.sv
`timescale 1ns/1ns

module rvCore #(
    parameter corePkg::word_t resetPc = '0
) (
    input  logic             clk, reset,
    input  corePkg::word_t   prdata,
    input  logic             pready,
    output corePkg::word_t   paddr,
    output logic             psel, penable, pwrite,
    output corePkg::word_t   pwdata,
    output logic             retireValid,
    output corePkg::word_t   retirePc,
    output corePkg::regIdx_t retireDst,
    output corePkg::word_t   retireData
);
    import corePkg::*;

    fetchData_t  dataF;
    decodeData_t dataD;
    execData_t   dataE;
    wbData_t     dataW;
    fwd_t        fwdE, fwdM;
    regIdx_t     rs1, rs2;
    word_t       q1, q2, branchTarget, rdata;
    word_t       fetchAddr, memAddr, memWdata;
    logic        fetchReq, fetchDone, memReq, memDone, memWrite;
    logic        execStall, bubble, branchTaken;

    wire fetchStall = execStall || bubble;

    busArbiter arbiter_i (
        .clk, .reset, .fetchReq, .fetchAddr, .memReq, .memAddr, .memWrite, .memWdata,
        .prdata, .pready, .fetchDone, .memDone, .rdata,
        .paddr, .psel, .penable, .pwrite, .pwdata
    );

    fetchStage #(.resetPc(resetPc)) fetch_i (
        .clk, .reset, .stall(fetchStall), .redirect(branchTaken), .redirectPc(branchTarget),
        .busDone(fetchDone), .busRdata(rdata), .busReq(fetchReq), .busAddr(fetchAddr),
        .dataF
    );

    decodeStage decode_i (
        .clk, .reset, .stall(execStall), .flush(branchTaken), .dataF, .fwdE, .fwdM,
        .q1, .q2, .rs1, .rs2, .bubble, .dataD
    );

    executeStage execute_i (
        .clk, .reset, .stall(execStall), .dataD, .branchTaken, .branchTarget, .fwdE, .dataE
    );

    memoryStage memory_i (
        .clk, .reset, .dataE, .busDone(memDone), .busRdata(rdata), .busReq(memReq),
        .busAddr(memAddr), .busWrite(memWrite), .busWdata(memWdata), .execStall, .fwdM,
        .dataW
    );

    regFile regFile_i (
        .clk, .reset, .rs1, .rs2, .dataW, .q1, .q2,
        .retireValid, .retirePc, .retireDst, .retireData
    );

endmodule

// File: verilog/regFile.sv
`timescale 1ns/1ns

module regFile (
    input  logic             clk, reset,
    input  corePkg::regIdx_t rs1, rs2,
    input  corePkg::wbData_t dataW,
    output corePkg::word_t   q1, q2,
    output logic             retireValid,
    output corePkg::word_t   retirePc,
    output corePkg::regIdx_t retireDst,
    output corePkg::word_t   retireData
);
    import corePkg::*;

    word_t regs [1:31];
    logic  writes, writeEn;

    assign writes  = dataW.valid && dataW.regWrite;
    assign writeEn = writes && dataW.dst != '0;

    always_ff @(posedge clk) begin
        if (writeEn)
            regs[dataW.dst] <= dataW.data;
    end

    // Same-cycle write is visible to the reader
    assign q1 = (rs1 == '0) ? '0 : (writeEn && rs1 == dataW.dst) ? dataW.data : regs[rs1];
    assign q2 = (rs2 == '0) ? '0 : (writeEn && rs2 == dataW.dst) ? dataW.data : regs[rs2];

    always_ff @(posedge clk) begin
        if (reset) begin
            retireValid <= 1'b0;
            retireDst   <= '0;
        end else begin
            retireValid <= dataW.valid;
            retireDst   <= writes ? dataW.dst : '0;
        end
    end

    always_ff @(posedge clk) begin
        retirePc   <= dataW.pc;
        retireData <= dataW.data;
    end

endmodule

// File: verilog/memoryStage.sv
`timescale 1ns/1ns

module memoryStage (
    input  logic               clk, reset,
    input  corePkg::execData_t dataE,
    input  logic               busDone,
    input  corePkg::word_t     busRdata,
    output logic               busReq,
    output corePkg::word_t     busAddr,
    output logic               busWrite,
    output corePkg::word_t     busWdata,
    output logic               execStall,
    output corePkg::fwd_t      fwdM,
    output corePkg::wbData_t   dataW
);
    import corePkg::*;

    logic isLoad;

    assign isLoad    = dataE.ctrl.kind == kindLoad;
    assign busReq    = dataE.valid && (isLoad || dataE.ctrl.kind == kindStore);
    assign busAddr   = dataE.result;
    assign busWrite  = dataE.ctrl.kind == kindStore;
    assign busWdata  = dataE.storeData;
    assign execStall = busReq && !busDone;

    assign fwdM = '{dst:    (dataW.valid && dataW.regWrite) ? dataW.dst : '0,
                    data:   dataW.data,
                    isLoad: 1'b0};

    always_ff @(posedge clk) begin
        if (reset) begin
            dataW.valid <= 1'b0;
        end else begin
            dataW <= '{valid:    dataE.valid && !execStall,    // Empty slot while waiting
                       pc:       dataE.pc,
                       dst:      dataE.dst,
                       data:     isLoad ? busRdata : dataE.result,
                       regWrite: dataE.ctrl.regWrite};
        end
    end

endmodule

// File: verilog/executeStage.sv
`timescale 1ns/1ns

module executeStage (
    input  logic                 clk, reset, stall,
    input  corePkg::decodeData_t dataD,
    output logic                 branchTaken,
    output corePkg::word_t       branchTarget,
    output corePkg::fwd_t        fwdE,
    output corePkg::execData_t   dataE
);
    import corePkg::*;

    word_t aluOut, result;
    logic  taken, equal;

    always_comb begin
        case (dataD.ctrl.aluOp)
            aluSub:   aluOut = dataD.srcA - dataD.srcB;
            aluAnd:   aluOut = dataD.srcA & dataD.srcB;
            aluOr:    aluOut = dataD.srcA | dataD.srcB;
            aluXor:   aluOut = dataD.srcA ^ dataD.srcB;
            aluSlt:   aluOut = word_t'($signed(dataD.srcA) < $signed(dataD.srcB));
            aluPassB: aluOut = dataD.srcB;
            default:  aluOut = dataD.srcA + dataD.srcB;
        endcase
    end

    assign equal = dataD.srcA == dataD.srcB;

    always_comb begin
        case (dataD.ctrl.kind)
            kindBranchEq: taken = equal;
            kindBranchNe: taken = !equal;
            kindJal:      taken = 1'b1;
            default:      taken = 1'b0;
        endcase
    end

    assign result       = (dataD.ctrl.kind == kindJal) ? dataD.pc + 32'd4 : aluOut;
    assign branchTaken  = dataD.valid && taken && !stall;    // Redirect once, as it leaves
    assign branchTarget = dataD.pc + dataD.imm;

    assign fwdE = '{dst:    (dataE.valid && dataE.ctrl.regWrite) ? dataE.dst : '0,
                    data:   dataE.result,
                    isLoad: dataE.ctrl.kind == kindLoad};

    always_ff @(posedge clk) begin
        if (reset) begin
            dataE.valid <= 1'b0;
        end else if (!stall) begin
            dataE <= '{valid: dataD.valid, pc: dataD.pc, ctrl: dataD.ctrl, dst: dataD.dst,
                       result: result, storeData: dataD.rs2Val};
        end
    end

endmodule

// File: verilog/decodeStage.sv
`timescale 1ns/1ns

module decodeStage (
    input  logic                 clk, reset, stall, flush,
    input  corePkg::fetchData_t  dataF,
    input  corePkg::fwd_t        fwdE, fwdM,
    input  corePkg::word_t       q1, q2,
    output corePkg::regIdx_t     rs1, rs2,
    output logic                 bubble,
    output corePkg::decodeData_t dataD
);
    import corePkg::*;

    ctrl_t   ctrl;
    word_t   imm, opA, opB;
    regIdx_t dstInExec;
    logic    useA, useB, hazardA, hazardB;

    function automatic word_t pickOperand(regIdx_t src, word_t rfVal);
        if (src == '0)
            return rfVal;    // x0 reads zero from the file
        if (src == fwdE.dst)
            return fwdE.data;
        if (src == fwdM.dst)
            return fwdM.data;
        return rfVal;
    endfunction

    instrDecoder decoder_i (
        .instr(dataF.instr),
        .ctrl (ctrl),
        .imm  (imm)
    );

    assign rs1 = dataF.instr[19:15];
    assign rs2 = dataF.instr[24:20];

    always_comb begin
        opA = pickOperand(rs1, q1);
        opB = pickOperand(rs2, q2);
    end

    // Fields that are really immediate bits must not stall the pipe
    assign useA = ctrl.kind != kindJal && ctrl.aluOp != aluPassB;
    assign useB = (!ctrl.useImm && ctrl.kind != kindJal) || ctrl.kind == kindStore;

    // Result of the instruction now in execute is not ready yet
    assign dstInExec = (dataD.valid && dataD.ctrl.regWrite) ? dataD.dst : '0;

    assign hazardA = useA && rs1 != '0 &&
                     (rs1 == dstInExec || (fwdE.isLoad && rs1 == fwdE.dst));
    assign hazardB = useB && rs2 != '0 &&
                     (rs2 == dstInExec || (fwdE.isLoad && rs2 == fwdE.dst));
    assign bubble  = dataF.valid && (hazardA || hazardB);

    always_ff @(posedge clk) begin
        if (reset) begin
            dataD.valid <= 1'b0;
        end else if (!stall) begin
            dataD <= '{
                valid:  dataF.valid && !bubble && !flush,
                pc:     dataF.pc,
                ctrl:   ctrl,
                dst:    dataF.instr[11:7],
                srcA:   opA,
                srcB:   ctrl.useImm ? imm : opB,
                rs2Val: opB,
                imm:    imm
            };
        end
    end

endmodule

// File: verilog/instrDecoder.sv
`timescale 1ns/1ns

module instrDecoder (
    input  corePkg::word_t instr,
    output corePkg::ctrl_t ctrl,
    output corePkg::word_t imm
);
    import corePkg::*;

    logic [6:0] opcode, funct7;
    logic [2:0] funct3;
    word_t      immI, immS, immB, immU, immJ;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    assign immI = {{20{instr[31]}}, instr[31:20]};
    assign immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign immB = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign immU = {instr[31:12], 12'b0};
    assign immJ = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        ctrl = '{kind: kindInvalid, aluOp: aluAdd, regWrite: 1'b0, useImm: 1'b0};
        imm  = '0;
        case (opcode)
            7'b0110011: begin    // Register-register
                ctrl.kind     = kindAlu;
                ctrl.regWrite = 1'b1;
                case ({funct7, funct3})
                    {7'h00, 3'b000}: ctrl.aluOp = aluAdd;
                    {7'h20, 3'b000}: ctrl.aluOp = aluSub;
                    {7'h00, 3'b111}: ctrl.aluOp = aluAnd;
                    {7'h00, 3'b110}: ctrl.aluOp = aluOr;
                    {7'h00, 3'b100}: ctrl.aluOp = aluXor;
                    {7'h00, 3'b010}: ctrl.aluOp = aluSlt;
                    default: begin
                        ctrl.kind     = kindInvalid;
                        ctrl.regWrite = 1'b0;
                    end
                endcase
            end
            7'b0010011: begin    // Register-immediate
                ctrl = '{kind: kindAlu, aluOp: aluAdd, regWrite: 1'b1, useImm: 1'b1};
                imm  = immI;
                case (funct3)
                    3'b000:  ctrl.aluOp = aluAdd;
                    3'b111:  ctrl.aluOp = aluAnd;
                    3'b110:  ctrl.aluOp = aluOr;
                    3'b100:  ctrl.aluOp = aluXor;
                    default: ctrl = '{kind: kindInvalid, aluOp: aluAdd, regWrite: 1'b0,
                                      useImm: 1'b0};
                endcase
            end
            7'b0110111: begin
                ctrl = '{kind: kindAlu, aluOp: aluPassB, regWrite: 1'b1, useImm: 1'b1};
                imm  = immU;
            end
            7'b0000011: begin
                if (funct3 == 3'b010)
                    ctrl = '{kind: kindLoad, aluOp: aluAdd, regWrite: 1'b1, useImm: 1'b1};
                imm = immI;
            end
            7'b0100011: begin
                if (funct3 == 3'b010)
                    ctrl = '{kind: kindStore, aluOp: aluAdd, regWrite: 1'b0, useImm: 1'b1};
                imm = immS;
            end
            7'b1100011: begin
                ctrl.aluOp = aluSub;
                if (funct3 == 3'b000)
                    ctrl.kind = kindBranchEq;
                else if (funct3 == 3'b001)
                    ctrl.kind = kindBranchNe;
                imm = immB;
            end
            7'b1101111: begin
                ctrl = '{kind: kindJal, aluOp: aluAdd, regWrite: 1'b1, useImm: 1'b0};
                imm  = immJ;
            end
            default: ;
        endcase
    end

endmodule

// File: verilog/fetchStage.sv
`timescale 1ns/1ns

module fetchStage #(
    parameter corePkg::word_t resetPc = '0
) (
    input  logic                clk, reset, stall, redirect,
    input  corePkg::word_t      redirectPc,
    input  logic                busDone,
    input  corePkg::word_t      busRdata,
    output logic                busReq,
    output corePkg::word_t      busAddr,
    output corePkg::fetchData_t dataF
);
    import corePkg::*;

    word_t pc;             // Address on the bus
    word_t savedTarget;    // Where to go once the stale word is back
    word_t bufPc, bufInstr;
    logic  bufValid, stale, consume;

    assign consume = bufValid && !stall;
    assign busReq  = !bufValid || consume;
    assign busAddr = pc;
    assign dataF   = '{valid: bufValid, pc: bufPc, instr: bufInstr};

    always_ff @(posedge clk) begin
        if (reset) begin
            pc       <= resetPc;
            stale    <= 1'b0;
            bufValid <= 1'b0;
        end else if (busDone) begin
            stale    <= 1'b0;
            bufValid <= !(stale || redirect);    // Drop words from the old path
            if (stale || redirect)
                pc <= redirect ? redirectPc : savedTarget;
            else
                pc <= pc + 32'd4;
        end else if (redirect) begin
            bufValid <= 1'b0;
            if (busReq) begin
                stale       <= 1'b1;    // Address must stay put until done
                savedTarget <= redirectPc;
            end else begin
                pc <= redirectPc;
            end
        end else if (consume) begin
            bufValid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (busDone) begin
            bufPc    <= pc;
            bufInstr <= busRdata;
        end
    end

endmodule

// File: verilog/busArbiter.sv
`timescale 1ns/1ns

module busArbiter (
    input  logic           clk, reset,
    input  logic           fetchReq,
    input  corePkg::word_t fetchAddr,
    input  logic           memReq,
    input  corePkg::word_t memAddr,
    input  logic           memWrite,
    input  corePkg::word_t memWdata,
    input  corePkg::word_t prdata,
    input  logic           pready,
    output logic           fetchDone,
    output logic           memDone,
    output corePkg::word_t rdata,
    output corePkg::word_t paddr,
    output logic           psel,
    output logic           penable,
    output logic           pwrite,
    output corePkg::word_t pwdata
);
    typedef enum logic [1:0] {phaseIdle, phaseSetup, phaseAccess} phase_t;

    phase_t phase;
    logic   grantMem;    // Owner of the current transfer
    logic   complete;

    always_ff @(posedge clk) begin
        if (reset) begin
            phase    <= phaseIdle;
            grantMem <= 1'b0;
        end else begin
            case (phase)
                phaseIdle: begin
                    if (memReq || fetchReq) begin
                        phase    <= phaseSetup;
                        grantMem <= memReq;    // Memory side wins a tie
                    end
                end
                phaseSetup:  phase <= phaseAccess;
                phaseAccess: if (pready) phase <= phaseIdle;
                default:     phase <= phaseIdle;
            endcase
        end
    end

    assign psel     = phase != phaseIdle;
    assign penable  = phase == phaseAccess;
    assign paddr    = grantMem ? memAddr : fetchAddr;
    assign pwrite   = grantMem && memWrite;
    assign pwdata   = grantMem ? memWdata : '0;
    assign complete = penable && pready;

    assign memDone   = complete && grantMem;
    assign fetchDone = complete && !grantMem;
    assign rdata     = prdata;

    // Owner keeps its request up until done
    ownerHoldsReq: assert property (@(posedge clk) disable iff (reset)
        psel |-> (grantMem ? memReq : fetchReq));

    // Requester must hold its address while the slave waits
    addrStable: assert property (@(posedge clk) disable iff (reset)
        (penable && !pready) |=> $stable(paddr));

endmodule

// File: verilog/corePkg.sv
package corePkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  regIdx_t;

    typedef enum logic [2:0] {
        aluAdd, aluSub, aluAnd, aluOr, aluXor, aluSlt, aluPassB
    } aluOp_t;

    typedef enum logic [2:0] {
        kindAlu, kindLoad, kindStore, kindBranchEq, kindBranchNe, kindJal, kindInvalid
    } instrKind_t;

    typedef struct packed {
        instrKind_t kind;
        aluOp_t     aluOp;
        logic       regWrite;
        logic       useImm;    // Operand B from the immediate
    } ctrl_t;

    typedef struct packed {
        logic  valid;
        word_t pc;
        word_t instr;
    } fetchData_t;

    typedef struct packed {
        logic    valid;
        word_t   pc;
        ctrl_t   ctrl;
        regIdx_t dst;
        word_t   srcA;
        word_t   srcB;
        word_t   rs2Val;    // Store data
        word_t   imm;
    } decodeData_t;

    typedef struct packed {
        regIdx_t dst;    // Zero when nothing is written
        word_t   data;
        logic    isLoad;
    } fwd_t;

    typedef struct packed {
        logic    valid;
        word_t   pc;
        ctrl_t   ctrl;
        regIdx_t dst;
        word_t   result;
        word_t   storeData;
    } execData_t;

    typedef struct packed {
        logic    valid;
        word_t   pc;
        regIdx_t dst;
        word_t   data;
        logic    regWrite;
    } wbData_t;

endpackage
